/* acq_link.f */
hdl/acq_link_pkg.sv
hdl/adc_scan.sv
hdl/pair_sequencer.sv
hdl/link_control.sv
hdl/tx_buffer.sv
hdl/serial_tx.sv
hdl/acq_link.sv
dv/acq_link_chk.sv
dv/acq_link_tb.sv

/* dv/acq_link_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol invariants between link_control, tx_buffer and the shifter
module acq_link_chk (
	input wire clock,
	input wire reset,
	input wire load,
	input wire send,
	input wire confirm,
	input wire tx_end,
	input wire send_en,
	input wire error
);

	// load and send are separate one cycle strobes
	load_send_apart: assert property (@(posedge clock) disable iff (reset)
		!(load && send))
		else $error("load and send high in the same cycle");

	// confirm only comes once the frame is over
	confirm_alone: assert property (@(posedge clock) disable iff (reset)
		!(confirm && (load || send)))
		else $error("confirm overlaps load or send");

	// a refused load or send never starts a frame
	error_blocks_send: assert property (@(posedge clock) disable iff (reset)
		error |-> !send_en)
		else $error("send_en high while error is set");

	tx_end_single: assert property (@(posedge clock) disable iff (reset)
		tx_end |=> !tx_end)
		else $error("tx_end longer than one cycle");

endmodule

// the link side has no send_en or error, the buffer side has no confirm
bind link_control acq_link_chk u_link_chk (
	.clock  (clock),
	.reset  (reset),
	.load   (load),
	.send   (send),
	.confirm(confirm),
	.tx_end (tx_end),
	.send_en(1'b0),
	.error  (1'b0)
);

bind tx_buffer acq_link_chk u_buffer_chk (
	.clock  (clock),
	.reset  (reset),
	.load   (load),
	.send   (send),
	.confirm(1'b0),
	.tx_end (tx_end),
	.send_en(send_en),
	.error  (error)
);

`default_nettype wire

/* dv/acq_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_link_tb;

	localparam int bit_delay = 4;
	// cycles per frame slot, and the offset to its middle
	localparam int bit_cycles = bit_delay + 1;
	localparam int half_bit = bit_cycles / 2;

	// selectors for wait_for_signal
	localparam int sel_soc = 0;
	localparam int sel_mux_en = 1;
	localparam int sel_load_dato = 2;
	localparam int sel_add_mpx2 = 3;
	localparam int sel_error = 4;

	logic       clock;
	logic       reset;
	logic       eoc;
	logic [7:0] data_in;
	logic       dsr;
	logic       soc;
	logic       load_dato;
	logic       add_mpx2;
	logic [3:0] canale;
	logic       mux_en;
	logic       error;
	logic       data_out;

	// channel that canale should show after the next scan
	logic [3:0] expected_chan;
	integer     seed;

	acq_link #(
		.bit_delay   (bit_delay),
		.num_channels(8)
	) DUT (
		.clock    (clock),
		.reset    (reset),
		.eoc      (eoc),
		.data_in  (data_in),
		.dsr      (dsr),
		.soc      (soc),
		.load_dato(load_dato),
		.add_mpx2 (add_mpx2),
		.canale   (canale),
		.mux_en   (mux_en),
		.error    (error),
		.data_out (data_out)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got == want) else begin
			$display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, got, want);
			stop_with_failure();
		end
	endtask

	// inputs change and outputs are sampled 1 ns after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	function automatic logic signal_of(input int sel);
		case (sel)
			sel_soc:       return soc;
			sel_mux_en:    return mux_en;
			sel_load_dato: return load_dato;
			sel_add_mpx2:  return add_mpx2;
			sel_error:     return error;
			default:       return data_out;
		endcase
	endfunction

	task automatic wait_for_signal(input int sel, input logic level, input string name,
			input int limit);
		int count;
		count = 0;
		while (signal_of(sel) !== level) begin
			assert (count < limit) else begin
				$display("timeout: %s did not reach %0d within %0d cycles", name, level, limit);
				stop_with_failure();
			end
			next_cycle();
			count++;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		eoc = 1'b1;
		dsr = 1'b1;
		data_in = 8'h00;
		repeat (16) next_cycle();
		reset = 1'b0;
		expected_chan = 4'd0;
	endtask

	// finds the falling edge of the start bit, then samples each slot in its middle
	task automatic receive_frame(output logic [7:0] value);
		int count;
		int bit_num;
		count = 0;
		value = 8'h00;
		while (data_out !== 1'b0) begin
			assert (count < 40 * bit_cycles) else begin
				$display("timeout: no start bit on data_out");
				stop_with_failure();
			end
			next_cycle();
			count++;
		end
		repeat (half_bit) next_cycle();
		assert (data_out == 1'b0) else begin
			$display("start bit on data_out is shorter than half a bit period");
			stop_with_failure();
		end
		// MSB first
		for (bit_num = 0; bit_num < 8; bit_num++) begin
			repeat (bit_cycles) next_cycle();
			value = {value[6:0], data_out};
		end
		repeat (bit_cycles) next_cycle();
		assert (data_out == 1'b1) else begin
			$display("stop bit on data_out is missing");
			stop_with_failure();
		end
	endtask

	// one conversion with eoc held busy for hold cycles, then the two frames of the pair
	task automatic scan_and_receive(input logic [7:0] value, input int hold);
		logic [7:0] got;
		int         idle;
		wait_for_signal(sel_soc, 1'b1, "soc", 100);
		repeat (hold) begin
			next_cycle();
			expect_equal("soc", 32'(soc), 32'd1);
			expect_equal("load_dato", 32'(load_dato), 32'd0);
		end
		data_in = value;
		eoc = 1'b0;
		wait_for_signal(sel_load_dato, 1'b1, "load_dato", 5);
		eoc = 1'b1;
		expect_equal("mux_en", 32'(mux_en), 32'd0);
		expected_chan = (expected_chan == 4'd7) ? 4'd0 : expected_chan + 4'd1;
		next_cycle();
		expect_equal("load_dato", 32'(load_dato), 32'd0);
		expect_equal("soc", 32'(soc), 32'd0);
		expect_equal("canale", 32'(canale), 32'(expected_chan));
		// first word goes out with add_mpx2 low
		expect_equal("add_mpx2", 32'(add_mpx2), 32'd0);
		receive_frame(got);
		expect_equal("first byte", 32'(got), 32'(value));
		expect_equal("add_mpx2", 32'(add_mpx2), 32'd0);
		wait_for_signal(sel_add_mpx2, 1'b1, "add_mpx2", 4 * bit_cycles);
		receive_frame(got);
		expect_equal("second byte", 32'(got), 32'(value));
		expect_equal("add_mpx2", 32'(add_mpx2), 32'd1);
		wait_for_signal(sel_add_mpx2, 1'b0, "add_mpx2", 4 * bit_cycles);
		expect_equal("error", 32'(error), 32'd0);
		// no third frame for this request
		for (idle = 0; idle < 3 * bit_cycles; idle++) begin
			next_cycle();
			expect_equal("data_out", 32'(data_out), 32'd1);
		end
	endtask

	task automatic check_reset_values();
		apply_reset();
		expect_equal("soc", 32'(soc), 32'd0);
		expect_equal("load_dato", 32'(load_dato), 32'd0);
		expect_equal("add_mpx2", 32'(add_mpx2), 32'd0);
		expect_equal("error", 32'(error), 32'd0);
		expect_equal("canale", 32'(canale), 32'd0);
		expect_equal("mux_en", 32'(mux_en), 32'd0);
		expect_equal("data_out", 32'(data_out), 32'd1);
		wait_for_signal(sel_mux_en, 1'b1, "mux_en", 5);
		expect_equal("soc", 32'(soc), 32'd0);
		wait_for_signal(sel_soc, 1'b1, "soc", 5);
	endtask

	// nine scans so canale wraps once
	task automatic scan_all_channels();
		int scan;
		apply_reset();
		for (scan = 0; scan < 9; scan++) begin
			scan_and_receive(8'h3c ^ 8'(scan), 2 + scan);
		end
	endtask

	task automatic send_pairs();
		apply_reset();
		scan_and_receive(8'h00, 1);
		scan_and_receive(8'hff, 1);
		scan_and_receive(8'h81, 3);
		scan_and_receive(8'h5a, 1);
	endtask

	task automatic send_random_bytes();
		int     scan;
		integer rnd;
		apply_reset();
		seed = 32'h97c6;
		for (scan = 0; scan < 20; scan++) begin
			rnd = $random(seed);
			scan_and_receive(rnd[7:0], 1 + (scan % 4));
		end
	endtask

	// a send with dsr low stalls the link until reset
	task automatic refuse_without_dsr();
		int count;
		apply_reset();
		dsr = 1'b0;
		wait_for_signal(sel_soc, 1'b1, "soc", 100);
		data_in = 8'hc3;
		eoc = 1'b0;
		wait_for_signal(sel_load_dato, 1'b1, "load_dato", 5);
		eoc = 1'b1;
		wait_for_signal(sel_error, 1'b1, "error", 20);
		for (count = 0; count < 20 * bit_cycles; count++) begin
			next_cycle();
			expect_equal("error", 32'(error), 32'd1);
			expect_equal("data_out", 32'(data_out), 32'd1);
		end
		apply_reset();
		expect_equal("error", 32'(error), 32'd0);
	endtask

	initial begin
		reset = 1'b1;
		eoc = 1'b1;
		dsr = 1'b1;
		data_in = 8'h00;
		expected_chan = 4'd0;
		seed = 32'h97c6;
		check_reset_values();
		scan_all_channels();
		send_pairs();
		send_random_bytes();
		refuse_without_dsr();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/acq_link.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_link #(
	parameter int bit_delay    = 104,
	parameter int num_channels = 8
) (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire                                 eoc,
	input  wire  [acq_link_pkg::data_width-1:0] data_in,
	input  wire                                 dsr,
	output logic                                soc,
	output logic                                load_dato,
	output logic                                add_mpx2,
	output logic [acq_link_pkg::chan_width-1:0] canale,
	output logic                                mux_en,
	output logic                                error,
	output logic                                data_out
);

	import acq_link_pkg::*;

	// scan to pair handshake
	logic send_data;
	logic rdy;
	// pair to link
	logic shot;
	logic confirm;
	// link to buffer
	logic load;
	logic send;
	// buffer to shifter
	logic [data_width-1:0] out_reg;
	logic                  send_en;
	logic                  tx_end;

	adc_scan #(
		.num_channels(num_channels)
	) u_adc_scan (
		.clock    (clock),
		.reset    (reset),
		.eoc      (eoc),
		.mux_en   (mux_en),
		.soc      (soc),
		.load_dato(load_dato),
		.canale   (canale),
		.send_data(send_data),
		.rdy      (rdy)
	);

	pair_sequencer u_pair_sequencer (
		.clock    (clock),
		.reset    (reset),
		.send_data(send_data),
		.rdy      (rdy),
		.shot     (shot),
		.confirm  (confirm),
		.add_mpx2 (add_mpx2)
	);

	link_control u_link_control (
		.clock  (clock),
		.reset  (reset),
		.shot   (shot),
		.load   (load),
		.send   (send),
		.tx_end (tx_end),
		.confirm(confirm)
	);

	tx_buffer u_tx_buffer (
		.clock  (clock),
		.reset  (reset),
		.load   (load),
		.send   (send),
		.data_in(data_in),
		.dsr    (dsr),
		.tx_end (tx_end),
		.out_reg(out_reg),
		.send_en(send_en),
		.error  (error)
	);

	serial_tx #(
		.bit_delay(bit_delay)
	) u_serial_tx (
		.clock   (clock),
		.reset   (reset),
		.send_en (send_en),
		.out_reg (out_reg),
		.data_out(data_out),
		.tx_end  (tx_end)
	);

endmodule

`default_nettype wire

/* hdl/acq_link_pkg.sv */
`default_nettype none

package acq_link_pkg;

	// width of a converted word, also the width of the serial byte
	localparam int data_width = 8;

	// width of the canale output toward the external multiplexer
	localparam int chan_width = 4;

	// converter scan sequence
	typedef enum logic [2:0] {
		scan_mux_on       = 3'd0,
		scan_settle       = 3'd1,
		scan_start_conv   = 3'd2,
		scan_wait_conv    = 3'd3,
		scan_latch        = 3'd4,
		scan_request      = 3'd5,
		scan_request_wait = 3'd6,
		scan_wait_ready   = 3'd7
	} scan_state_t;

	// two link shots per scan request
	typedef enum logic [1:0] {
		pair_idle         = 2'd0,
		pair_fire         = 2'd1,
		pair_wait_confirm = 2'd2,
		pair_finish       = 2'd3
	} pair_state_t;

	// load, send and confirm toward the transmit buffer
	typedef enum logic [1:0] {
		link_idle     = 2'd0,
		link_load     = 2'd1,
		link_send     = 2'd2,
		link_wait_end = 2'd3
	} link_state_t;

	// frame slots, the data slots are consecutive so the bit index can be derived
	typedef enum logic [3:0] {
		slot_start = 4'd0,
		slot_bit0  = 4'd1,
		slot_bit1  = 4'd2,
		slot_bit2  = 4'd3,
		slot_bit3  = 4'd4,
		slot_bit4  = 4'd5,
		slot_bit5  = 4'd6,
		slot_bit6  = 4'd7,
		slot_bit7  = 4'd8,
		slot_stop  = 4'd9
	} bit_slot_t;

endpackage

`default_nettype wire

/* hdl/adc_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_scan #(
	parameter int num_channels = 8
) (
	input  wire                                   clock,
	input  wire                                   reset,
	input  wire                                   eoc,
	output logic                                  mux_en,
	output logic                                  soc,
	output logic                                  load_dato,
	output logic [acq_link_pkg::chan_width-1:0]   canale,
	output logic                                  send_data,
	input  wire                                   rdy
);

	import acq_link_pkg::*;

	// highest channel number before the counter wraps
	localparam logic [chan_width-1:0] last_channel = chan_width'(num_channels - 1);

	scan_state_t state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= scan_mux_on;
			mux_en    <= 1'b0;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			canale    <= '0;
			send_data <= 1'b0;
		end else begin
			case (state)
				// enable the multiplexer first
				scan_mux_on: begin
					mux_en <= 1'b1;
					state  <= scan_settle;
				end
				// one idle cycle so the analog path settles
				scan_settle: begin
					state <= scan_start_conv;
				end
				scan_start_conv: begin
					soc   <= 1'b1;
					state <= scan_wait_conv;
				end
				// eoc high means the converter is still busy, hold here
				scan_wait_conv: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= scan_latch;
					end
				end
				// load_dato is a single cycle strobe
				scan_latch: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					// next channel, wraps after num_channels
					if (canale == last_channel) begin
						canale <= '0;
					end else begin
						canale <= canale + 1'b1;
					end
					state <= scan_request;
				end
				scan_request: begin
					send_data <= 1'b1;
					state     <= scan_request_wait;
				end
				// give the pair stage a cycle to react
				scan_request_wait: begin
					state <= scan_wait_ready;
				end
				scan_wait_ready: begin
					if (rdy) begin
						send_data <= 1'b0;
						state     <= scan_mux_on;
					end
				end
				default: begin
					state <= scan_mux_on;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/link_control.sv */
`timescale 1ns/1ps
`default_nettype none

module link_control (
	input  wire  clock,
	input  wire  reset,
	input  wire  shot,
	output logic load,
	output logic send,
	input  wire  tx_end,
	output logic confirm
);

	import acq_link_pkg::*;

	link_state_t state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= link_idle;
			load    <= 1'b0;
			send    <= 1'b0;
			confirm <= 1'b0;
		end else begin
			case (state)
				// confirm only lasts the cycle after tx_end
				link_idle: begin
					confirm <= 1'b0;
					if (shot) begin
						load  <= 1'b1;
						state <= link_load;
					end
				end
				// byte goes into the buffer, then ask for transmission
				link_load: begin
					load  <= 1'b0;
					send  <= 1'b1;
					state <= link_send;
				end
				link_send: begin
					send  <= 1'b0;
					state <= link_wait_end;
				end
				// stays here for good if the buffer refused the send
				link_wait_end: begin
					if (tx_end) begin
						confirm <= 1'b1;
						state   <= link_idle;
					end
				end
				default: begin
					state <= link_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/pair_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_sequencer (
	input  wire  clock,
	input  wire  reset,
	input  wire  send_data,
	output logic rdy,
	output logic shot,
	input  wire  confirm,
	output logic add_mpx2
);

	import acq_link_pkg::*;

	pair_state_t state;

	// set once the first word of the pair has been confirmed
	logic mpx;

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= pair_idle;
			rdy      <= 1'b0;
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
			mpx      <= 1'b0;
		end else begin
			case (state)
				// accept a scan request
				pair_idle: begin
					if (send_data) begin
						rdy   <= 1'b1;
						state <= pair_fire;
					end
				end
				// one cycle shot toward the link
				pair_fire: begin
					shot  <= 1'b1;
					state <= pair_wait_confirm;
				end
				pair_wait_confirm: begin
					shot <= 1'b0;
					if (confirm) begin
						if (!mpx) begin
							// first word done, the second one goes out flagged
							mpx      <= 1'b1;
							add_mpx2 <= 1'b1;
							state    <= pair_fire;
						end else begin
							// pair complete
							mpx      <= 1'b0;
							add_mpx2 <= 1'b0;
							rdy      <= 1'b0;
							state    <= pair_finish;
						end
					end
				end
				// one quiet cycle before the next request is taken
				pair_finish: begin
					state <= pair_idle;
				end
				default: begin
					state <= pair_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/serial_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_tx #(
	parameter int bit_delay = 104
) (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire                                 send_en,
	input  wire  [acq_link_pkg::data_width-1:0] out_reg,
	output logic                                data_out,
	output logic                                tx_end
);

	import acq_link_pkg::*;

	// timer counts 0 to bit_delay, so each slot is bit_delay+1 cycles
	localparam int timer_width = (bit_delay > 0) ? $clog2(bit_delay + 1) : 1;
	localparam logic [timer_width-1:0] timer_last = timer_width'(bit_delay);

	bit_slot_t              slot;
	logic [timer_width-1:0] timer;
	logic [2:0]             bit_index;
	logic                   frame_bit;
	logic                   active;

	// hold off for the tx_end cycle, send_en drops on the next edge
	assign active = send_en && !tx_end;

	// bit0 carries the MSB
	assign bit_index = 3'(data_width - int'(slot));

	// line level for the current slot
	always_comb begin
		case (slot)
			slot_start: frame_bit = 1'b0;
			slot_stop:  frame_bit = 1'b1;
			default:    frame_bit = out_reg[bit_index];
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			slot     <= slot_start;
			timer    <= '0;
			data_out <= 1'b1;
			tx_end   <= 1'b0;
		end else begin
			tx_end <= 1'b0;
			if (active) begin
				// output lags the slot by one cycle, same for every slot
				data_out <= frame_bit;
				if (timer == timer_last) begin
					timer <= '0;
					if (slot == slot_stop) begin
						slot   <= slot_start;
						tx_end <= 1'b1;
					end else begin
						slot <= bit_slot_t'(slot + 4'd1);
					end
				end else begin
					timer <= timer + 1'b1;
				end
			end else begin
				// idle line is high
				data_out <= 1'b1;
				timer    <= '0;
				slot     <= slot_start;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/tx_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_buffer (
	input  wire                                 clock,
	input  wire                                 reset,
	input  wire                                 load,
	input  wire                                 send,
	input  wire  [acq_link_pkg::data_width-1:0] data_in,
	input  wire                                 dsr,
	input  wire                                 tx_end,
	output logic [acq_link_pkg::data_width-1:0] out_reg,
	output logic                                send_en,
	output logic                                error
);

	// buffer holds a byte not yet sent
	logic full;

	// later assignments win, so load and send override the tx_end clear
	always_ff @(posedge clock) begin
		if (reset) begin
			out_reg <= '0;
			full    <= 1'b0;
			send_en <= 1'b0;
			error   <= 1'b0;
		end else begin
			// frame finished, buffer free again
			if (tx_end) begin
				send_en <= 1'b0;
				full    <= 1'b0;
			end
			// overwrite of a pending byte is an error
			if (load) begin
				if (!full) begin
					out_reg <= data_in;
					full    <= 1'b1;
					error   <= 1'b0;
				end else begin
					error <= 1'b1;
				end
			end
			// nothing to send, or the far end is not ready
			if (send) begin
				if (!full || !dsr) begin
					error <= 1'b1;
				end else begin
					error   <= 1'b0;
					send_en <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the acq_link testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module acq_link_tb \
	-Mdir obj_dir -f acq_link.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/Vacq_link_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
